/* source/isa_pkg.sv */
package isa_pkg;

    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;
    localparam int SHAMT_W  = $clog2(XLEN);

    localparam logic [XLEN-1:0] RESET_PC = '0;
    localparam logic [XLEN-1:0] PC_STEP  = 4;

    // Major opcodes, instruction[6:0]
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } br_funct_e;

    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } alu_funct_e;

    // Only word accesses on the data port
    localparam logic [2:0] F3_WORD = 3'b010;

    localparam logic [6:0] F7_ZERO = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

/* source/ctrl_pkg.sv */
package ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_AND    = 4'b0000,
        ALU_OR     = 4'b0001,
        ALU_ADD    = 4'b0010,
        ALU_SLTU   = 4'b0011,
        ALU_SLT    = 4'b0100,
        ALU_PASS_B = 4'b0101,
        ALU_SUB    = 4'b0110,
        ALU_SLL    = 4'b1000,
        ALU_XOR    = 4'b1001,
        ALU_SRL    = 4'b1100,
        ALU_SRA    = 4'b1101
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I = 3'd1,
        IMM_S = 3'd2,
        IMM_B = 3'd3,
        IMM_U = 3'd4,
        IMM_J = 3'd5
    } imm_sel_e;

    typedef enum logic [1:0] {
        WB_MEM = 2'b00,
        WB_ALU = 2'b01,
        WB_PC4 = 2'b10
    } wb_sel_e;

    // Operand select levels
    localparam logic A_RS1 = 1'b0;
    localparam logic A_PC  = 1'b1;
    localparam logic B_RS2 = 1'b0;
    localparam logic B_IMM = 1'b1;

endpackage

/* source/ctrl_if.sv */
`timescale 1ns/1ps

interface ctrl_if import isa_pkg::*, ctrl_pkg::*; ();

    logic            a_sel;
    logic            b_sel;
    alu_op_e         alu_op;
    logic            br_un;
    logic [XLEN-1:0] imm;
    logic            reg_wen;
    logic            mem_wr;
    wb_sel_e         wb_sel;
    logic            pc_sel;

    modport dec (
        output a_sel, b_sel, alu_op, br_un, imm,
        output reg_wen, mem_wr, wb_sel, pc_sel
    );

    modport ex (
        input a_sel, b_sel, alu_op, br_un, imm
    );

    modport res (
        input reg_wen, wb_sel, pc_sel
    );

endinterface

/* source/instr_ctl.sv */
`timescale 1ns/1ps

module instr_ctl import isa_pkg::*, ctrl_pkg::*; (
    input  logic [XLEN-1:0]   instruction,
    input  logic              br_eq,
    input  logic              br_lt,
    ctrl_if.dec               ctrl,
    output logic [REG_AW-1:0] rs1_addr,
    output logic [REG_AW-1:0] rs2_addr,
    output logic [REG_AW-1:0] rd_addr
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    imm_sel_e   imm_sel;
    alu_op_e    arith_op;
    logic       arith_legal;
    logic       br_taken;
    logic       is_jump;
    logic       is_branch;

    assign opcode   = opcode_e'(instruction[6:0]);
    assign funct3   = instruction[14:12];
    assign funct7   = instruction[31:25];
    assign rd_addr  = instruction[11:7];
    assign rs1_addr = instruction[19:15];
    assign rs2_addr = instruction[24:20];

    // ALU operation for the OP and OP-IMM groups
    always_comb begin
        arith_op    = ALU_ADD;
        arith_legal = (opcode == OP_IMM) || (funct7 == F7_ZERO);
        case (alu_funct_e'(funct3))
            F3_ADD: begin
                if (opcode == OP_REG && funct7 == F7_ALT) begin
                    arith_op    = ALU_SUB;
                    arith_legal = 1'b1;
                end
            end
            F3_SLL: begin
                arith_op    = ALU_SLL;
                arith_legal = (funct7 == F7_ZERO);
            end
            F3_SLT:  arith_op = ALU_SLT;
            F3_SLTU: arith_op = ALU_SLTU;
            F3_XOR:  arith_op = ALU_XOR;
            F3_SR: begin
                arith_op    = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                arith_legal = (funct7 == F7_ZERO) || (funct7 == F7_ALT);
            end
            F3_OR:   arith_op = ALU_OR;
            F3_AND:  arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        case (br_funct_e'(funct3))
            BR_BEQ:          br_taken = br_eq;
            BR_BNE:          br_taken = !br_eq;
            BR_BLT, BR_BLTU: br_taken = br_lt;
            BR_BGE, BR_BGEU: br_taken = !br_lt;
            default:         br_taken = 1'b0;
        endcase
    end

    // Everything defaults to a no-op
    always_comb begin
        ctrl.a_sel   = A_RS1;
        ctrl.b_sel   = B_IMM;
        ctrl.alu_op  = ALU_ADD;
        ctrl.br_un   = 1'b0;
        ctrl.reg_wen = 1'b0;
        ctrl.mem_wr  = 1'b0;
        ctrl.wb_sel  = WB_ALU;
        imm_sel      = IMM_I;
        is_jump      = 1'b0;
        is_branch    = 1'b0;
        case (opcode)
            OP_LUI: begin
                ctrl.alu_op  = ALU_PASS_B;
                ctrl.reg_wen = 1'b1;
                imm_sel      = IMM_U;
            end
            OP_AUIPC: begin
                ctrl.a_sel   = A_PC;
                ctrl.reg_wen = 1'b1;
                imm_sel      = IMM_U;
            end
            OP_JAL: begin
                ctrl.a_sel   = A_PC;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel  = WB_PC4;
                imm_sel      = IMM_J;
                is_jump      = 1'b1;
            end
            OP_JALR: begin
                ctrl.reg_wen = (funct3 == 3'b000);
                ctrl.wb_sel  = WB_PC4;
                is_jump      = (funct3 == 3'b000);
            end
            OP_BRANCH: begin
                ctrl.a_sel = A_PC;
                // Unsigned compare for BLTU and BGEU
                ctrl.br_un = funct3[1];
                imm_sel    = IMM_B;
                is_branch  = 1'b1;
            end
            OP_LOAD: begin
                ctrl.reg_wen = (funct3 == F3_WORD);
                ctrl.wb_sel  = WB_MEM;
            end
            OP_STORE: begin
                ctrl.mem_wr = (funct3 == F3_WORD);
                imm_sel     = IMM_S;
            end
            OP_IMM: begin
                ctrl.alu_op  = arith_op;
                ctrl.reg_wen = arith_legal;
            end
            OP_REG: begin
                ctrl.b_sel   = B_RS2;
                ctrl.alu_op  = arith_op;
                ctrl.reg_wen = arith_legal;
            end
            default: ;
        endcase
    end

    assign ctrl.pc_sel = is_jump || (is_branch && br_taken);

    always_comb begin
        case (imm_sel)
            IMM_S: ctrl.imm = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
            IMM_B: ctrl.imm = {{19{instruction[31]}}, instruction[31], instruction[7],
                               instruction[30:25], instruction[11:8], 1'b0};
            IMM_U: ctrl.imm = {instruction[31:12], 12'b0};
            IMM_J: ctrl.imm = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                               instruction[20], instruction[30:21], 1'b0};
            default: ctrl.imm = {{20{instruction[31]}}, instruction[31:20]};
        endcase
    end

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file import isa_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [REG_AW-1:0] rs1_addr,
    input  logic [REG_AW-1:0] rs2_addr,
    input  logic [REG_AW-1:0] rd_addr,
    input  logic              wen,
    input  logic [XLEN-1:0]   wdata,
    output logic [XLEN-1:0]   rs1_data,
    output logic [XLEN-1:0]   rs2_data
);

    logic [XLEN-1:0] regs [NUM_REGS];

    // x0 is never written so it stays at its reset value
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd_addr != '0) begin
            regs[rd_addr] <= wdata;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

/* source/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit import isa_pkg::*, ctrl_pkg::*; (
    ctrl_if.ex              ctrl,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    output logic [XLEN-1:0] alu_result,
    output logic            br_eq,
    output logic            br_lt
);

    logic [XLEN-1:0]    op_a;
    logic [XLEN-1:0]    op_b;
    logic [SHAMT_W-1:0] shamt;

    assign op_a  = (ctrl.a_sel == A_PC) ? pc : rs1_data;
    assign op_b  = (ctrl.b_sel == B_IMM) ? ctrl.imm : rs2_data;
    assign shamt = op_b[SHAMT_W-1:0];

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SLT:    alu_result = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_result = XLEN'(op_a < op_b);
            ALU_SLL:    alu_result = op_a << shamt;
            ALU_SRL:    alu_result = op_a >> shamt;
            ALU_SRA:    alu_result = XLEN'($signed(op_a) >>> shamt);
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    // Branch comparator works on the registers, not the ALU operands
    assign br_eq = (rs1_data == rs2_data);
    assign br_lt = ctrl.br_un ? (rs1_data < rs2_data)
                              : ($signed(rs1_data) < $signed(rs2_data));

endmodule

/* source/result_stage.sv */
`timescale 1ns/1ps

module result_stage import isa_pkg::*, ctrl_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    ctrl_if.res             ctrl,
    input  logic [XLEN-1:0] alu_result,
    input  logic [XLEN-1:0] mem_rdata,
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] wb_data,
    output logic            wb_en
);

    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] pc_next;

    assign pc_plus4 = pc + PC_STEP;

    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:  wb_data = mem_rdata;
            WB_PC4:  wb_data = pc_plus4;
            default: wb_data = alu_result;
        endcase
    end

    // Bit 0 cleared on every redirect
    // JAL and branch targets are already even so only JALR is affected
    assign pc_next = ctrl.pc_sel ? {alu_result[XLEN-1:1], 1'b0} : pc_plus4;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // No register write while held in reset
    assign wb_en = ctrl.reg_wen && arst_n;

endmodule

/* source/rv_core.sv */
`timescale 1ns/1ps

module rv_core import isa_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    output logic [XLEN-1:0]   imem_addr,
    input  logic [XLEN-1:0]   imem_data,
    output logic [XLEN-1:0]   dmem_addr,
    output logic [XLEN-1:0]   dmem_wdata,
    output logic              dmem_wr,
    input  logic [XLEN-1:0]   dmem_rdata,
    output logic [XLEN-1:0]   retire_pc,
    output logic              rd_wen,
    output logic [REG_AW-1:0] rd_addr,
    output logic [XLEN-1:0]   rd_data
);

    logic [XLEN-1:0]   pc;
    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [XLEN-1:0]   alu_result;
    logic              br_eq;
    logic              br_lt;

    ctrl_if ctrl ();

    instr_ctl instr_ctl_inst (
        .instruction (imem_data),
        .br_eq       (br_eq),
        .br_lt       (br_lt),
        .ctrl        (ctrl.dec),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rd_addr     (rd_addr)
    );

    reg_file reg_file_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr),
        .wen      (rd_wen),
        .wdata    (rd_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    exec_unit exec_unit_inst (
        .ctrl       (ctrl.ex),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .br_eq      (br_eq),
        .br_lt      (br_lt)
    );

    result_stage result_stage_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .ctrl       (ctrl.res),
        .alu_result (alu_result),
        .mem_rdata  (dmem_rdata),
        .pc         (pc),
        .wb_data    (rd_data),
        .wb_en      (rd_wen)
    );

    assign imem_addr  = pc;
    assign retire_pc  = pc;
    assign dmem_addr  = alu_result;
    assign dmem_wdata = rs2_data;
    // Memory must not see a store while the core sits in reset
    assign dmem_wr    = ctrl.mem_wr && arst_n;

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk
);

    // 8 ns period
    localparam int HALF_PERIOD = 4;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

/* dv/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb import isa_pkg::*; ();

    localparam logic [31:0] SEED = 32'hdc3d_b234;

    logic        clk;
    logic        arst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_wr;
    logic [31:0] dmem_rdata;
    logic [31:0] retire_pc;
    logic        rd_wen;
    logic [4:0]  rd_addr;
    logic [31:0] rd_data;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] m_regs [32];
    logic [31:0] m_dmem [64];
    logic [31:0] m_pc;
    int          prog_len;
    int          timeout_cycles;
    int          cycle_count = 0;
    logic [31:0] done_pc;

    // Expected retire fields of the instruction in the current cycle
    logic        exp_wen;
    logic        exp_wr;
    logic [4:0]  exp_rd;
    logic [31:0] exp_pc;
    logic [31:0] exp_data;
    logic [31:0] exp_addr;
    logic [31:0] exp_sdata;
    logic [31:0] exp_npc;

    tb_clk_gen tb_clk_gen_inst (.clk(clk));

    rv_core rv_core_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wr    (dmem_wr),
        .dmem_rdata (dmem_rdata),
        .retire_pc  (retire_pc),
        .rd_wen     (rd_wen),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    assign imem_data  = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    function automatic logic [31:0] fill_word(input logic [5:0] idx);
        return 32'hc0de_0000 | {24'd0, idx, 2'b00};
    endfunction

    always @(posedge clk) begin
        if (!arst_n) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= fill_word(6'(i));
            end
        end else if (dmem_wr) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    // Skipped when a branch or jump redirects, so a wrong PC shows up in the trace
    task automatic emit_filler();
        emit(enc_i(12'd1, 5'd13, F3_ADD, 5'd13, OP_IMM));
    endtask

    task automatic emit_branch(input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2);
        emit(enc_b(13'd8, rs2, rs1, f3));
        emit_filler();
    endtask

    task automatic build_program();
        logic [11:0] off;
        for (int i = 0; i < 64; i++) begin
            imem[i] = '0;
        end
        prog_len = 0;
        for (int r = 1; r <= 2; r++) begin
            emit(enc_u(20'($urandom()), 5'(r), OP_LUI));
            emit(enc_i(12'($urandom()), 5'(r), F3_ADD, 5'(r), OP_IMM));
        end
        for (int f = 0; f < 8; f++) begin
            if (f == 1 || f == 5) begin
                emit(enc_i({F7_ZERO, 5'($urandom())}, 5'd1, 3'(f), 5'd3, OP_IMM));
            end else begin
                emit(enc_i(12'($urandom()), 5'd1, 3'(f), 5'd3, OP_IMM));
            end
        end
        emit(enc_i({F7_ALT, 5'($urandom())}, 5'd1, F3_SR, 5'd3, OP_IMM));
        for (int f = 0; f < 8; f++) begin
            emit(enc_r(F7_ZERO, 5'd2, 5'd1, 3'(f), 5'd4));
        end
        emit(enc_r(F7_ALT, 5'd2, 5'd1, F3_ADD, 5'd4));
        emit(enc_r(F7_ALT, 5'd2, 5'd1, F3_SR, 5'd4));
        // x0 must read back as zero after a write
        emit(enc_i(12'($urandom()), 5'd1, F3_ADD, 5'd0, OP_IMM));
        emit(enc_r(F7_ZERO, 5'd2, 5'd0, F3_ADD, 5'd7));
        off = {4'd0, 6'($urandom()), 2'b00};
        emit(enc_s(off, 5'd1, 5'd0));
        emit(enc_i(off, 5'd0, F3_WORD, 5'd8, OP_LOAD));
        emit(enc_u(20'($urandom()), 5'd9, OP_LUI));
        emit(enc_u(20'($urandom()), 5'd10, OP_AUIPC));
        emit(enc_j(21'd8, 5'd11));
        emit_filler();
        // Odd target so bit 0 has to be dropped
        emit(enc_i(12'(4 * prog_len + 9), 5'd0, 3'b000, 5'd12, OP_JALR));
        emit_filler();
        emit(enc_r(7'b0000001, 5'd2, 5'd1, F3_ADD, 5'd5));
        emit(32'h0000_000f);
        emit(enc_i(12'd0, 5'd0, 3'b000, 5'd6, OP_LOAD));
        emit_branch(BR_BEQ, 5'd1, 5'd1);
        emit_branch(BR_BEQ, 5'd1, 5'd2);
        emit_branch(BR_BNE, 5'd1, 5'd1);
        emit_branch(BR_BNE, 5'd1, 5'd2);
        emit_branch(BR_BLT, 5'd1, 5'd2);
        emit_branch(BR_BLT, 5'd2, 5'd1);
        emit_branch(BR_BGE, 5'd1, 5'd2);
        emit_branch(BR_BGE, 5'd2, 5'd1);
        emit_branch(BR_BLTU, 5'd1, 5'd2);
        emit_branch(BR_BLTU, 5'd2, 5'd1);
        emit_branch(BR_BGEU, 5'd1, 5'd2);
        emit_branch(BR_BGEU, 5'd2, 5'd1);
        done_pc = 32'(4 * prog_len);
        emit(enc_j(21'd0, 5'd0));
    endtask

    // RV32I rules for the OP and OP-IMM groups
    // Legal flag sits in bit 32 above the result
    function automatic logic [32:0] alu_ref(input logic [2:0] f3, input logic [6:0] f7,
                                            input logic [31:0] a, input logic [31:0] b,
                                            input logic is_reg);
        logic        ok;
        logic [31:0] v;
        ok = !is_reg || f7 == F7_ZERO;
        v  = '0;
        case (alu_funct_e'(f3))
            F3_ADD: begin
                if (is_reg && f7 == F7_ALT) begin
                    v  = a - b;
                    ok = 1'b1;
                end else begin
                    v = a + b;
                end
            end
            F3_SLL: begin
                v  = a << b[4:0];
                ok = (f7 == F7_ZERO);
            end
            F3_SLT:  v = {31'd0, $signed(a) < $signed(b)};
            F3_SLTU: v = {31'd0, a < b};
            F3_XOR:  v = a ^ b;
            F3_SR: begin
                if (f7 == F7_ALT) begin
                    v = $signed(a) >>> b[4:0];
                end else begin
                    v = a >> b[4:0];
                end
                ok = (f7 == F7_ZERO) || (f7 == F7_ALT);
            end
            F3_OR:   v = a | b;
            F3_AND:  v = a & b;
        endcase
        return {ok, v};
    endfunction

    task automatic predict(input logic [31:0] pc, output logic wen, output logic [4:0] rd,
                           output logic [31:0] wdata, output logic wr,
                           output logic [31:0] addr, output logic [31:0] sdata,
                           output logic [31:0] npc);
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [2:0]  f3;
        logic        take;
        logic [32:0] alu;
        instr = imem[pc[7:2]];
        a     = m_regs[instr[19:15]];
        b     = m_regs[instr[24:20]];
        f3    = instr[14:12];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        rd    = instr[11:7];
        wen   = 1'b0;
        wr    = 1'b0;
        wdata = '0;
        addr  = '0;
        sdata = b;
        npc   = pc + 32'd4;
        case (instr[6:0])
            OP_LUI: begin
                wen   = 1'b1;
                wdata = {instr[31:12], 12'd0};
            end
            OP_AUIPC: begin
                wen   = 1'b1;
                wdata = pc + {instr[31:12], 12'd0};
            end
            OP_JAL: begin
                wen   = 1'b1;
                wdata = pc + 32'd4;
                npc   = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            OP_JALR: begin
                if (f3 == 3'b000) begin
                    wen   = 1'b1;
                    wdata = pc + 32'd4;
                    npc   = (a + imm_i) & ~32'd1;
                end
            end
            OP_BRANCH: begin
                case (br_funct_e'(f3))
                    BR_BEQ:  take = (a == b);
                    BR_BNE:  take = (a != b);
                    BR_BLT:  take = ($signed(a) < $signed(b));
                    BR_BGE:  take = ($signed(a) >= $signed(b));
                    BR_BLTU: take = (a < b);
                    BR_BGEU: take = (a >= b);
                    default: take = 1'b0;
                endcase
                if (take) begin
                    npc = pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                end
            end
            OP_LOAD: begin
                if (f3 == F3_WORD) begin
                    wen   = 1'b1;
                    addr  = a + imm_i;
                    wdata = m_dmem[addr[7:2]];
                end
            end
            OP_STORE: begin
                if (f3 == F3_WORD) begin
                    wr   = 1'b1;
                    addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
                end
            end
            OP_IMM, OP_REG: begin
                alu   = alu_ref(f3, instr[31:25], a, (instr[6:0] == OP_REG) ? b : imm_i,
                                instr[6:0] == OP_REG);
                wen   = alu[32];
                wdata = alu[31:0];
            end
            default: ;
        endcase
    endtask

    // Reference model retires one instruction per clock, in step with the DUT
    always @(posedge clk) begin : ref_model
        logic        n_wen;
        logic        n_wr;
        logic [4:0]  n_rd;
        logic [31:0] n_data;
        logic [31:0] n_addr;
        logic [31:0] n_sdata;
        logic [31:0] n_npc;
        if (!arst_n) begin
            m_pc = '0;
            for (int i = 0; i < 32; i++) begin
                m_regs[i] = '0;
            end
            for (int i = 0; i < 64; i++) begin
                m_dmem[i] = fill_word(6'(i));
            end
        end else begin
            if (exp_wen && exp_rd != 5'd0) begin
                m_regs[exp_rd] = exp_data;
            end
            if (exp_wr) begin
                m_dmem[exp_addr[7:2]] = exp_sdata;
            end
            m_pc = exp_npc;
        end
        predict(m_pc, n_wen, n_rd, n_data, n_wr, n_addr, n_sdata, n_npc);
        exp_pc    <= m_pc;
        exp_wen   <= n_wen;
        exp_rd    <= n_rd;
        exp_data  <= n_data;
        exp_wr    <= n_wr;
        exp_addr  <= n_addr;
        exp_sdata <= n_sdata;
        exp_npc   <= n_npc;
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    reset_quiet: assert property (@(posedge clk)
        !arst_n |-> (!rd_wen && !dmem_wr && retire_pc == '0))
        else abort_run($sformatf("FAIL t=%0t: outputs active or PC nonzero in reset", $time));

    pc_match: assert property (@(posedge clk) arst_n |-> retire_pc == exp_pc)
        else abort_run($sformatf("FAIL t=%0t: retire_pc %h, expected %h",
                                 $time, $sampled(retire_pc), $sampled(exp_pc)));

    fetch_match: assert property (@(posedge clk) arst_n |-> imem_addr == exp_pc)
        else abort_run($sformatf("FAIL t=%0t: imem_addr %h, expected %h",
                                 $time, $sampled(imem_addr), $sampled(exp_pc)));

    wen_match: assert property (@(posedge clk) arst_n |-> rd_wen == exp_wen)
        else abort_run($sformatf("FAIL t=%0t: rd_wen %b at pc %h, expected %b",
                                 $time, $sampled(rd_wen), $sampled(exp_pc), $sampled(exp_wen)));

    wb_match: assert property (@(posedge clk)
        (arst_n && exp_wen) |-> (rd_addr == exp_rd && rd_data == exp_data))
        else abort_run($sformatf("FAIL t=%0t: write x%0d=%h, expected x%0d=%h",
                                 $time, $sampled(rd_addr), $sampled(rd_data),
                                 $sampled(exp_rd), $sampled(exp_data)));

    wr_match: assert property (@(posedge clk) arst_n |-> dmem_wr == exp_wr)
        else abort_run($sformatf("FAIL t=%0t: dmem_wr %b at pc %h, expected %b",
                                 $time, $sampled(dmem_wr), $sampled(exp_pc), $sampled(exp_wr)));

    store_match: assert property (@(posedge clk)
        (arst_n && exp_wr) |-> (dmem_addr == exp_addr && dmem_wdata == exp_sdata))
        else abort_run($sformatf("FAIL t=%0t: store [%h]=%h, expected [%h]=%h",
                                 $time, $sampled(dmem_addr), $sampled(dmem_wdata),
                                 $sampled(exp_addr), $sampled(exp_sdata)));

    initial begin : main
        void'($urandom(SEED));
        arst_n = 1'b0;
        build_program();
        timeout_cycles = prog_len * 4;
        repeat (16) @(posedge clk);
        #1 arst_n = 1'b1;
        while (retire_pc !== done_pc && cycle_count < timeout_cycles) begin
            @(posedge clk);
            #1;
        end
        if (retire_pc !== done_pc) begin
            abort_run($sformatf("Timeout: final loop not reached within %0d cycles",
                                timeout_cycles));
        end else begin
            // Let the final loop retire twice under the checks
            repeat (2) @(posedge clk);
            #1;
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

/* rv_core.f */
source/isa_pkg.sv
source/ctrl_pkg.sv
source/ctrl_if.sv
source/instr_ctl.sv
source/reg_file.sv
source/exec_unit.sv
source/result_stage.sv
source/rv_core.sv
dv/tb_clk_gen.sv
dv/rv_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=rv_core_tb
build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$top" -f rv_core.f -o "V$top" > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    cat "$build_log"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/V$top > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$sim_log"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: pass message not found in $sim_log"
    exit 1
fi
